// File: holo_macros.svh
// holo command path constants shared by the UART, SPI, reset and reply blocks
`ifndef HOLO_MACROS_SVH
`define HOLO_MACROS_SVH

////////////////////
// host uart
////////////////////
// fpga_clk cycles per uart bit
// 62.5 MHz / 3.125 Mbaud gives an exact divide
`define HOLO_UART_CLKS_PER_BIT 20

////////////////////
// display spi
////////////////////
// fpga_clk cycles per sck half period
// one sck period is 4 cycles
`define HOLO_SPI_HALF_PERIOD 2

////////////////////
// slm reset
////////////////////
// cycles the slm reset stays low once its cause ends
// 10 cycles at 62.5 MHz is 160 ns
`define HOLO_RST_STRETCH 10
// register address that requests a hard reset instead of a write
`define HOLO_RST_ADDR 8'hBD

// reply bytes that can wait for the uart transmitter
`define HOLO_REPLY_DEPTH 4

`endif

// File: holo_pkg.sv
// holo command path types: host bytes and the 16-bit display register command word
`default_nettype none

package holo_pkg;

  // one host or register byte
  typedef logic [7:0] byte_t;

  // one spi register write
  // raw view feeds the spi shift register
  // cmd view is the address byte then the data byte, address goes out first
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      byte_t addr;
      byte_t data;
    } cmd;
  } spi_word_u;

endpackage

`default_nettype wire

// File: uart_rx.sv
// host uart receiver, 8N1, one-cycle strobe per received byte
`timescale 1ns/100ps
`default_nettype none
`include "holo_macros.svh"

module uart_rx (
  input  logic            fpga_clk,
  input  logic            reset_all_cmd_w,
  input  logic            rx_serial_i,
  output logic            rx_valid_o,
  output holo_pkg::byte_t rx_byte_o
);
  import holo_pkg::*;

  localparam int CLKS  = `HOLO_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS);
  // last cycle of a full bit, and the start bit midpoint
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS / 2 - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic             rx_meta_q;
  logic             rx_sync_q;
  logic [1:0]       state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;

  // two flops on the asynchronous host line, idle high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= ST_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge, maybe a start bit
          if (!rx_sync_q) begin
            state_q <= ST_START;
          end
        end
        ST_START: begin
          if (clk_cnt_q == HALF_END) begin
            clk_cnt_q <= '0;
            // still low at mid bit, otherwise a glitch
            state_q <= rx_sync_q ? ST_IDLE : ST_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_DATA: begin
          if (clk_cnt_q == BIT_END) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= ST_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          // middle of the stop bit, byte is complete
          if (clk_cnt_q == BIT_END) begin
            clk_cnt_q  <= '0;
            rx_valid_o <= 1'b1;
            state_q    <= ST_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb arrives first, so shift in from the top
  always_ff @(posedge fpga_clk) begin
    if (state_q == ST_DATA && clk_cnt_q == BIT_END) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_byte_o = shift_q;

endmodule

`default_nettype wire

// File: uart_tx.sv
// host uart transmitter, 8N1, busy from start request until the stop bit ends
`timescale 1ns/100ps
`default_nettype none
`include "holo_macros.svh"

module uart_tx (
  input  logic            fpga_clk,
  input  logic            reset_all_cmd_w,
  input  logic            tx_start_i,
  input  holo_pkg::byte_t tx_byte_i,
  output logic            tx_serial_o,
  output logic            tx_busy_o
);
  import holo_pkg::*;

  localparam int CLKS  = `HOLO_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic [1:0]       state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= ST_IDLE;
      clk_cnt_q   <= '0;
      bit_idx_q   <= '0;
      tx_serial_o <= 1'b1;
      tx_busy_o   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // start request only taken here, ignored while busy
          if (tx_start_i) begin
            shift_q     <= tx_byte_i;
            tx_serial_o <= 1'b0;
            tx_busy_o   <= 1'b1;
            state_q     <= ST_START;
          end
        end
        ST_START: begin
          if (clk_cnt_q == BIT_END) begin
            clk_cnt_q   <= '0;
            // first data bit, lsb first
            tx_serial_o <= shift_q[0];
            shift_q     <= shift_q >> 1;
            state_q     <= ST_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_DATA: begin
          if (clk_cnt_q == BIT_END) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              tx_serial_o <= 1'b1;
              state_q     <= ST_STOP;
            end else begin
              tx_serial_o <= shift_q[0];
              shift_q     <= shift_q >> 1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          // stop bit, line already high
          if (clk_cnt_q == BIT_END) begin
            clk_cnt_q <= '0;
            tx_busy_o <= 1'b0;
            state_q   <= ST_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: host_cmd_decoder.sv
// host byte pairing into spi register writes, hard-reset command and slm reset stretch
`timescale 1ns/100ps
`default_nettype none
`include "holo_macros.svh"

module host_cmd_decoder (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                rx_valid_i,
  input  holo_pkg::byte_t     rx_byte_i,
  output logic                spi_start_o,
  output holo_pkg::spi_word_u spi_word_o,
  output logic                slm_reset_n_o
);
  import holo_pkg::*;

  localparam int STRETCH = `HOLO_RST_STRETCH;
  localparam int RST_W   = $clog2(STRETCH + 1);
  localparam logic [RST_W-1:0] RST_LOAD = RST_W'(STRETCH);
  localparam byte_t RST_ADDR = `HOLO_RST_ADDR;

  logic       addr_pending_q;
  byte_t      addr_q;
  spi_word_u  spi_word_q;
  logic       rst_cmd;
  logic [RST_W-1:0] rst_cnt_q;

  ////////////////////
  // byte pairing
  ////////////////////
  // first byte of a pair is the address, second is the data
  // reset address on the second byte means hard reset, no spi write
  assign rst_cmd = rx_valid_i && addr_pending_q && (addr_q == RST_ADDR);

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      addr_pending_q <= 1'b0;
      spi_start_o    <= 1'b0;
    end else begin
      spi_start_o <= 1'b0;
      if (rx_valid_i) begin
        addr_pending_q <= !addr_pending_q;
        // data byte of a normal pair, fire the write
        if (addr_pending_q && (addr_q != RST_ADDR)) begin
          spi_start_o <= 1'b1;
        end
      end
    end
  end

  // address and command word are payload
  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i && !addr_pending_q) begin
      addr_q <= rx_byte_i;
    end
    if (rx_valid_i && addr_pending_q) begin
      spi_word_q.cmd.addr <= addr_q;
      spi_word_q.cmd.data <= rx_byte_i;
    end
  end

  assign spi_word_o = spi_word_q;

  ////////////////////
  // slm reset stretch
  ////////////////////
  // loaded while the global reset is high, or by the reset command
  // counts down once its cause is gone
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rst_cnt_q <= RST_LOAD;
    end else if (rst_cmd) begin
      rst_cnt_q <= RST_LOAD;
    end else if (rst_cnt_q != '0) begin
      rst_cnt_q <= rst_cnt_q - 1'b1;
    end
  end

  // active low, released when the count is spent
  assign slm_reset_n_o = (rst_cnt_q == '0);

endmodule

`default_nettype wire

// File: spi_master.sv
// spi master for 16-bit display register writes, mode 0, captures the reply byte
`timescale 1ns/100ps
`default_nettype none
`include "holo_macros.svh"

module spi_master (
  input  logic                fpga_clk,
  input  logic                reset_all_cmd_w,
  input  logic                spi_start_i,
  input  holo_pkg::spi_word_u spi_word_i,
  output logic                sck_o,
  output logic                sen_o,
  output logic                sdat_o,
  input  logic                sout_i,
  output logic                reply_valid_o,
  output holo_pkg::byte_t     reply_byte_o
);
  import holo_pkg::*;

  localparam int HALF  = `HOLO_SPI_HALF_PERIOD;
  localparam int DIV_W = ($clog2(HALF) > 0) ? $clog2(HALF) : 1;
  localparam logic [DIV_W-1:0] DIV_END = DIV_W'(HALF - 1);

  logic             busy_q;
  logic [DIV_W-1:0] div_q;
  logic [3:0]       bit_cnt_q;
  spi_word_u        shift_q;
  byte_t            reply_q;
  logic             half_tick;

  // one sck half period has passed
  assign half_tick = busy_q && (div_q == DIV_END);

  ////////////////////
  // transfer control
  ////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      busy_q        <= 1'b0;
      div_q         <= '0;
      bit_cnt_q     <= '0;
      sck_o         <= 1'b0;
      sen_o         <= 1'b1;
      reply_valid_o <= 1'b0;
      shift_q.raw   <= '0;
    end else begin
      reply_valid_o <= 1'b0;
      if (!busy_q) begin
        // new write, sen drops on the next cycle
        if (spi_start_i) begin
          busy_q      <= 1'b1;
          sen_o       <= 1'b0;
          sck_o       <= 1'b0;
          div_q       <= '0;
          bit_cnt_q   <= '0;
          shift_q.raw <= spi_word_i.raw;
        end
      end else if (half_tick) begin
        div_q <= '0;
        if (!sck_o) begin
          // rising edge, slave samples sdat
          sck_o <= 1'b1;
        end else if (bit_cnt_q == 4'd15) begin
          // last period done, close the frame
          sck_o         <= 1'b0;
          sen_o         <= 1'b1;
          busy_q        <= 1'b0;
          reply_valid_o <= 1'b1;
        end else begin
          // falling edge, next bit onto sdat
          sck_o       <= 1'b0;
          shift_q.raw <= {shift_q.raw[14:0], 1'b0};
          bit_cnt_q   <= bit_cnt_q + 1'b1;
        end
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  // msb first
  assign sdat_o = shift_q.raw[15];

  ////////////////////
  // reply capture
  ////////////////////
  // sout sampled at each rising edge of the data phase, msb first
  always_ff @(posedge fpga_clk) begin
    if (half_tick && !sck_o && bit_cnt_q[3]) begin
      reply_q <= {reply_q[6:0], sout_i};
    end
  end

  assign reply_byte_o = reply_q;

endmodule

`default_nettype wire

// File: reply_queue.sv
// reply byte FIFO between the spi master and the uart transmitter, with drain control
`timescale 1ns/100ps
`default_nettype none
`include "holo_macros.svh"

module reply_queue (
  input  logic            fpga_clk,
  input  logic            reset_all_cmd_w,
  input  logic            reply_valid_i,
  input  holo_pkg::byte_t reply_byte_i,
  input  logic            tx_busy_i,
  output logic            tx_start_o,
  output holo_pkg::byte_t tx_byte_o
);
  import holo_pkg::*;

  // depth is a power of two, pointers wrap on their own
  localparam int DEPTH = `HOLO_REPLY_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  byte_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // full queue drops the reply
  assign push = reply_valid_i && (count_q != FULL_CNT);
  // no pop while a start is still on its way to the transmitter
  assign pop  = (count_q != '0) && !tx_busy_i && !tx_start_o;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_o <= 1'b0;
    end else begin
      // pop now, transmit start one cycle later
      tx_start_o <= pop;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage and held transmit byte
  always_ff @(posedge fpga_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= reply_byte_i;
    end
    if (pop) begin
      tx_byte_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

// File: holo_ctrl.sv
// holo board host command path: uart bytes to spi register writes, replies back over uart
`timescale 1ns/100ps
`default_nettype none

module holo_ctrl (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic sen_o,
  output logic sck_o,
  output logic sdat_o,
  input  logic sout_i,
  output logic slm_reset_n_o
);
  import holo_pkg::*;

  // host receive side
  logic      rx_valid;
  byte_t     rx_byte;
  // register write request
  logic      spi_start;
  spi_word_u spi_word;
  // spi reply
  logic      reply_valid;
  byte_t     reply_byte;
  // host transmit side
  logic      tx_start;
  byte_t     tx_byte;
  logic      tx_busy;

  uart_rx i_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  host_cmd_decoder i_host_cmd_decoder (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  spi_master i_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_start_i     (spi_start),
    .spi_word_i      (spi_word),
    .sck_o           (sck_o),
    .sen_o           (sen_o),
    .sdat_o          (sdat_o),
    .sout_i          (sout_i),
    .reply_valid_o   (reply_valid),
    .reply_byte_o    (reply_byte)
  );

  reply_queue i_reply_queue (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .reply_valid_i   (reply_valid),
    .reply_byte_i    (reply_byte),
    .tx_busy_i       (tx_busy),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx i_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_serial_o     (uart_tx_o),
    .tx_busy_o       (tx_busy)
  );

endmodule

`default_nettype wire

// File: holo_ctrl_checker.sv
// bound checker for the holo command path: spi framing, transmit start and slm reset release
`timescale 1ns/100ps
`default_nettype none
`include "holo_macros.svh"

module holo_ctrl_checker (
  input logic fpga_clk,
  input logic reset_all_cmd_w,
  input logic sen_i,
  input logic sck_i,
  input logic tx_start_i,
  input logic tx_busy_i,
  input logic slm_reset_n_i
);

  localparam int STRETCH  = `HOLO_RST_STRETCH;
  // 16 sck periods of two half periods each
  localparam int SEN_LOW  = 32 * `HOLO_SPI_HALF_PERIOD;

  logic [7:0] sen_low_cnt_q;
  logic [4:0] rel_cnt_q;

  ////////////////////
  // helper counters
  ////////////////////
  // cycles sen has been low in the current frame
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w || sen_i) begin
      sen_low_cnt_q <= '0;
    end else begin
      sen_low_cnt_q <= sen_low_cnt_q + 8'd1;
    end
  end

  // cycles since global reset release, saturating
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rel_cnt_q <= '0;
    end else if (rel_cnt_q != 5'd31) begin
      rel_cnt_q <= rel_cnt_q + 5'd1;
    end
  end

  ////////////////////
  // rules
  ////////////////////
  // mode 0, clock parked low outside a frame
  sck_idle_low: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    sen_i |-> !sck_i)
    else $error("sck high while sen is high");

  // one frame is 16 full sck periods
  sen_frame_len: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    $rose(sen_i) |-> (sen_low_cnt_q == 8'(SEN_LOW)))
    else $error("sen low for %0d cycles in one frame", sen_low_cnt_q);

  // queue must never start the transmitter mid byte
  tx_start_idle: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    tx_start_i |-> !tx_busy_i)
    else $error("tx_start while uart transmitter busy");

  // slm reset held for the stretch, released exactly at its end
  rst_release: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    (rel_cnt_q <= 5'(STRETCH)) |-> (slm_reset_n_i == (rel_cnt_q == 5'(STRETCH))))
    else $error("slm reset level wrong %0d cycles after reset release", rel_cnt_q);

endmodule

bind holo_ctrl holo_ctrl_checker i_holo_ctrl_checker (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .sen_i           (sen_o),
  .sck_i           (sck_o),
  .tx_start_i      (tx_start),
  .tx_busy_i       (tx_busy),
  .slm_reset_n_i   (slm_reset_n_o)
);

`default_nettype wire

// File: tb_holo_ctrl.sv
// testbench for the holo command path: host uart pairs in, spi writes and uart replies checked
`timescale 1ns/100ps
`default_nettype none
`include "holo_macros.svh"

module tb_holo_ctrl;
  import holo_pkg::*;

  localparam int CLKS         = `HOLO_UART_CLKS_PER_BIT;
  localparam int BYTE_CYCLES  = 10 * CLKS;
  localparam int SPI_CYCLES   = 32 * `HOLO_SPI_HALF_PERIOD;
  localparam int STRETCH      = `HOLO_RST_STRETCH;
  localparam int RESET_CYCLES = 8;
  // 12 host bytes, 5 of the 6 pairs are register writes
  localparam int NUM_BYTES    = 12;
  localparam int NUM_WRITES   = 5;
  localparam int MAX_CYCLES   = 2 * (NUM_BYTES * BYTE_CYCLES + NUM_WRITES * SPI_CYCLES)
                                + 3 * BYTE_CYCLES;
  localparam byte_t RST_ADDR  = `HOLO_RST_ADDR;

  logic fpga_clk        = 1'b0;
  logic reset_all_cmd_w = 1'b1;
  logic uart_rx_i       = 1'b1;
  logic sout_i          = 1'b0;
  logic uart_tx_o;
  logic sen_o;
  logic sck_o;
  logic sdat_o;
  logic slm_reset_n_o;

  integer    seed      = 32'h75a5;
  int        cycle_cnt = 0;
  int        err_spi   = 0;
  int        err_reply = 0;
  int        err_frame = 0;
  int        err_other = 0;
  logic      watch_rst = 1'b0;
  int        low_cnt   = 0;
  // scoreboard queues
  spi_word_u exp_words[$];
  spi_word_u got_words[$];
  byte_t     exp_replies[$];
  byte_t     got_replies[$];
  int        cmd_pulses[$];

  holo_ctrl i_dut (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .sdat_o          (sdat_o),
    .sout_i          (sout_i),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  // 8 ns period
  always #4 fpga_clk = ~fpga_clk;

  ////////////////////
  // reference and checks
  ////////////////////
  // slave answers each write with its address scrambled by 0x5a
  function automatic byte_t ref_reply(input spi_word_u w);
    return w.cmd.addr ^ 8'h5A;
  endfunction

  task automatic check_spi_word(input spi_word_u got, input spi_word_u exp);
    if (got !== exp) begin
      err_spi++;
      $display("Fail %0t: SPI word %h, expected %h", $time, got.raw, exp.raw);
    end
  endtask

  task automatic check_reply(input byte_t got, input byte_t exp);
    if (got !== exp) begin
      err_reply++;
      $display("Fail %0t: UART reply %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_other++;
      $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_pulse(input int got, input int exp, input string what);
    if (got != exp) begin
      err_other++;
      $display("Fail %0t: %s low for %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // host side stimulus
  ////////////////////
  // any byte except the hard-reset address
  task automatic pick_byte(output byte_t b);
    b = byte_t'($random(seed));
    while (b == RST_ADDR) begin
      b = byte_t'($random(seed));
    end
  endtask

  // called on a falling edge, 8N1
  task automatic send_byte(input byte_t b);
    byte_t sh;
    sh = b;
    uart_rx_i = 1'b0;
    repeat (CLKS) @(negedge fpga_clk);
    // lsb first
    repeat (8) begin
      uart_rx_i = sh[0];
      sh = sh >> 1;
      repeat (CLKS) @(negedge fpga_clk);
    end
    uart_rx_i = 1'b1;
    repeat (CLKS) @(negedge fpga_clk);
  endtask

  task automatic send_pair(input byte_t addr, input byte_t data);
    spi_word_u w;
    w.cmd.addr = addr;
    w.cmd.data = data;
    // reset command makes no write and no reply
    if (addr != RST_ADDR) begin
      exp_words.push_back(w);
      exp_replies.push_back(ref_reply(w));
    end
    send_byte(addr);
    send_byte(data);
  endtask

  task automatic wait_drained();
    while (exp_words.size() != 0 || exp_replies.size() != 0) begin
      @(negedge fpga_clk);
    end
  endtask

  ////////////////////
  // bus models
  ////////////////////
  // spi slave, edges seen at the falling clock where sck and sdat are stable
  initial begin : spi_slave
    spi_word_u  word;
    byte_t      reply;
    logic [4:0] bit_n;
    logic       sck_prev;
    logic       sen_prev;
    word     = '0;
    reply    = '0;
    bit_n    = '0;
    sck_prev = 1'b0;
    sen_prev = 1'b1;
    forever begin
      @(negedge fpga_clk);
      // rising sck, capture msb first
      if (!sen_o && sck_o && !sck_prev) begin
        word.raw[4'd15 - bit_n[3:0]] = sdat_o;
        bit_n = bit_n + 5'd1;
      end
      // falling sck in the data phase, next reply bit
      if (!sen_o && !sck_o && sck_prev && bit_n >= 5'd8 && bit_n < 5'd16) begin
        reply  = ref_reply(word);
        sout_i = reply[3'd7 - bit_n[2:0]];
      end
      if (sen_o && !sen_prev) begin
        got_words.push_back(word);
        bit_n = '0;
      end
      sck_prev = sck_o;
      sen_prev = sen_o;
    end
  end

  // uart reply decoder, samples at bit centers
  initial begin : uart_monitor
    byte_t rx_b;
    rx_b = '0;
    wait (reset_all_cmd_w == 1'b0);
    forever begin
      @(negedge fpga_clk);
      if (uart_tx_o == 1'b0) begin
        repeat (CLKS / 2) @(negedge fpga_clk);
        repeat (8) begin
          repeat (CLKS) @(negedge fpga_clk);
          rx_b = {uart_tx_o, rx_b[7:1]};
        end
        repeat (CLKS) @(negedge fpga_clk);
        if (uart_tx_o !== 1'b1) begin
          err_frame++;
          $display("UART reply %h at %0t has no stop bit", rx_b, $time);
        end
        got_replies.push_back(rx_b);
      end
    end
  end

  // slm reset pulses after power-up
  always @(negedge fpga_clk) begin
    if (watch_rst) begin
      if (!slm_reset_n_o) begin
        low_cnt = low_cnt + 1;
      end else if (low_cnt != 0) begin
        cmd_pulses.push_back(low_cnt);
        low_cnt = 0;
      end
    end
  end

  // compare against expectations, in order
  always @(negedge fpga_clk) begin : compare_results
    spi_word_u w;
    byte_t     b;
    if (got_words.size() != 0) begin
      w = got_words.pop_front();
      if (exp_words.size() == 0) begin
        err_spi++;
        $display("SPI write %h at %0t with no host pair behind it", w.raw, $time);
      end else begin
        check_spi_word(w, exp_words.pop_front());
      end
    end
    if (got_replies.size() != 0) begin
      b = got_replies.pop_front();
      if (exp_replies.size() == 0) begin
        err_reply++;
        $display("UART reply %h at %0t with no SPI write behind it", b, $time);
      end else begin
        check_reply(b, exp_replies.pop_front());
      end
    end
  end

  // run limit
  always @(posedge fpga_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: test still running after %0d cycles", MAX_CYCLES);
      $display("errors: spi %0d, reply %0d, frame %0d, other %0d",
               err_spi, err_reply, err_frame, err_other);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // test sequence
  ////////////////////
  initial begin : main_seq
    byte_t a;
    byte_t d;
    int    n;
    repeat (RESET_CYCLES) @(negedge fpga_clk);
    reset_all_cmd_w = 1'b0;
    // idle levels
    check_level(sen_o, 1'b1, "SEN after reset");
    check_level(sck_o, 1'b0, "SCK after reset");
    check_level(uart_tx_o, 1'b1, "UART_TX after reset");
    // power-up stretch
    n = 0;
    while (!slm_reset_n_o && n < 4 * STRETCH) begin
      n++;
      @(negedge fpga_clk);
    end
    check_pulse(n, STRETCH, "power-up SLM reset");
    watch_rst = 1'b1;
    // one write, reply awaited
    pick_byte(a);
    pick_byte(d);
    send_pair(a, d);
    wait_drained();
    // three pairs while replies go out
    repeat (3) begin
      pick_byte(a);
      pick_byte(d);
      send_pair(a, d);
    end
    wait_drained();
    // hard reset, then pairing must restart cleanly
    pick_byte(d);
    send_pair(RST_ADDR, d);
    pick_byte(a);
    pick_byte(d);
    send_pair(a, d);
    wait_drained();
    // room for any stray write or reply
    repeat (2 * BYTE_CYCLES) @(negedge fpga_clk);
    if (cmd_pulses.size() != 1) begin
      err_other++;
      $display("expected one SLM reset pulse from the command, saw %0d", cmd_pulses.size());
    end else begin
      check_pulse(cmd_pulses[0], STRETCH, "command SLM reset");
    end
    $display("errors: spi %0d, reply %0d, frame %0d, other %0d",
             err_spi, err_reply, err_frame, err_other);
    if (err_spi + err_reply + err_frame + err_other == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: holo_ctrl.f
+incdir+.
holo_pkg.sv
uart_rx.sv
uart_tx.sv
host_cmd_decoder.sv
spi_master.sv
reply_queue.sv
holo_ctrl.sv
holo_ctrl_checker.sv
tb_holo_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the holo_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_holo_ctrl \
  -f holo_ctrl.f -o sim_holo_ctrl || exit 1
out=$(./obj_dir/sim_holo_ctrl)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && echo "run ok" || { echo "run not ok"; exit 1; }
